// ==== filelist.f ====
cpu_pkg.sv
mem_bus_pkg.sv
line_ram.sv
mem_bus_guard.sv
mem_subsystem_top.sv
tb_clock_gen.sv
mem_bus_guard_asserts.sv
tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mem_subsystem
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VERILATOR_FLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

	import cpu_pkg::*;
	import mem_bus_pkg::*;

	localparam int PORT_INSTR = 0;
	localparam int PORT_DATA = 1;
	localparam int PORT_WRITE = 2;
	localparam int WAIT_LIMIT = 8;
	localparam int RANDOM_OPS = 40;
	// sum of the per test budgets in cycles
	// one single access takes about 6
	localparam int WATCHDOG_CYCLES = 10 + 20 + 20 + 40 + (RANDOM_OPS + 2) * 10 + 30 + 100;
	localparam cpu_addr_t ALIAS_MASK = 32'hffff_f800;

	logic clk;
	logic rst;
	read_req_t req_read_instr;
	read_req_t req_read_data;
	write_req_t req_write_data;
	read_rsp_t rsp_read_instr;
	read_rsp_t rsp_read_data;
	write_rsp_t rsp_write_data;

	// reference copy of the RAM lines
	line_data_t ref_lines [RAM_DEPTH];
	int seed;
	int checks;
	int errors;

	tb_clock_gen clk_gen_i
	(
		.clk (clk)
	);

	mem_subsystem_top dut_i
	(
		.clk            (clk),
		.rst            (rst),
		.req_read_instr (req_read_instr),
		.req_read_data  (req_read_data),
		.req_write_data (req_write_data),
		.rsp_read_instr (rsp_read_instr),
		.rsp_read_data  (rsp_read_data),
		.rsp_write_data (rsp_write_data)
	);

	// 8 bits above the 3 byte offset bits
	// higher bits alias onto the same line
	function automatic int ref_index(input cpu_addr_t addr);
		return int'(addr[10:3]);
	endfunction

	function automatic logic [2:0] port_mask(input int port);
		return 3'b100 >> port;
	endfunction

	// cmd_accepted bits then valid bits with instruction read first
	function automatic logic [5:0] pulse_vec();
		return {rsp_read_instr.cmd_accepted, rsp_read_data.cmd_accepted,
			rsp_write_data.cmd_accepted, rsp_read_instr.valid, rsp_read_data.valid,
			rsp_write_data.valid};
	endfunction

	task automatic report_failure(input string msg);
		errors++;
		$display("%0t ns: %s", $time, msg);
	endtask

	task automatic check_line(input string what, input line_data_t got, input line_data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bits(input string what, input logic [5:0] got, input logic [5:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s, got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_int(input string what, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic drive_read(input int port, input logic req, input cpu_addr_t addr);
		if (port == PORT_INSTR)
		begin
			req_read_instr.req = req;
			req_read_instr.addr = addr;
		end
		else
		begin
			req_read_data.req = req;
			req_read_data.addr = addr;
		end
	endtask

	task automatic drive_write(input logic req, input cpu_addr_t addr, input line_data_t data);
		req_write_data.req = req;
		req_write_data.addr = addr;
		req_write_data.data = data;
	endtask

	// returns on the falling edge where the port's cmd_accepted is seen
	task automatic wait_accept(input int port);
		logic [5:0] pulses;
		int n;
		n = 0;
		pulses = '0;
		while ((pulses[5:3] & port_mask(port)) == 3'b000 && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			pulses = pulse_vec();
			n++;
		end
		if ((pulses[5:3] & port_mask(port)) == 3'b000)
		begin
			report_failure($sformatf("port %0d never got cmd_accepted", port));
		end
	endtask

	task automatic wait_valid(input int port, output int cycles);
		logic [5:0] pulses;
		cycles = 0;
		pulses = '0;
		while ((pulses[2:0] & port_mask(port)) == 3'b000 && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			pulses = pulse_vec();
			cycles++;
		end
		if ((pulses[2:0] & port_mask(port)) == 3'b000)
		begin
			report_failure($sformatf("port %0d never returned valid", port));
		end
		else
		begin
			// only the expected port may show valid
			check_bits("pulses at valid", pulses, {3'b000, port_mask(port)});
		end
	endtask

	task automatic write_line(input cpu_addr_t addr, input line_data_t data);
		int lat;
		@(negedge clk);
		drive_write(1'b1, addr, data);
		wait_accept(PORT_WRITE);
		drive_write(1'b0, addr, data);
		wait_valid(PORT_WRITE, lat);
		check_int("write valid delay after cmd_accepted", lat, 2);
		ref_lines[ref_index(addr)] = data;
	endtask

	task automatic read_check(input int port, input cpu_addr_t addr);
		int lat;
		line_data_t exp;
		line_data_t got;
		exp = ref_lines[ref_index(addr)];
		@(negedge clk);
		drive_read(port, 1'b1, addr);
		wait_accept(port);
		drive_read(port, 1'b0, addr);
		wait_valid(port, lat);
		check_int("read valid delay after cmd_accepted", lat, 2);
		got = (port == PORT_INSTR) ? rsp_read_instr.data : rsp_read_data.data;
		check_line($sformatf("read data port %0d addr %h", port, addr), got, exp);
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_bits("pulses after reset", pulse_vec(), 6'b000000);
		check_line("instr data after reset", rsp_read_instr.data, '0);
		check_line("data read data after reset", rsp_read_data.data, '0);
	endtask

	task automatic test_write_then_read();
		write_line(32'h0000_0010, 64'h0123_4567_89ab_cdef);
		read_check(PORT_DATA, 32'h0000_0010);
	endtask

	task automatic test_instr_read();
		write_line(32'h0000_0058, 64'hfeed_face_cafe_f00d);
		read_check(PORT_INSTR, 32'h0000_0058);
		// the data port still holds the line of its last read
		check_line("data port line after instr read", rsp_read_data.data,
			ref_lines[ref_index(32'h0000_0010)]);
	endtask

	// all three raised together get accepted as instr, data and write on consecutive edges
	task automatic test_priority();
		cpu_addr_t addr_a;
		cpu_addr_t addr_b;
		line_data_t new_a;
		addr_a = 32'h0000_0140;
		addr_b = 32'h0000_0188;
		new_a = 64'h5555_aaaa_5555_aaaa;
		write_line(addr_a, 64'h1111_2222_3333_4444);
		write_line(addr_b, 64'h9999_8888_7777_6666);
		@(negedge clk);
		drive_read(PORT_INSTR, 1'b1, addr_b);
		drive_read(PORT_DATA, 1'b1, addr_a);
		drive_write(1'b1, addr_a, new_a);
		@(negedge clk);
		check_bits("priority step 1", pulse_vec(), 6'b100_000);
		drive_read(PORT_INSTR, 1'b0, addr_b);
		@(negedge clk);
		check_bits("priority step 2", pulse_vec(), 6'b010_000);
		drive_read(PORT_DATA, 1'b0, addr_a);
		@(negedge clk);
		check_bits("priority step 3", pulse_vec(), 6'b001_100);
		check_line("priority instr data", rsp_read_instr.data, ref_lines[ref_index(addr_b)]);
		drive_write(1'b0, addr_a, new_a);
		@(negedge clk);
		check_bits("priority step 4", pulse_vec(), 6'b000_010);
		// read was accepted before the write, so it sees the old line
		check_line("priority data read", rsp_read_data.data, ref_lines[ref_index(addr_a)]);
		@(negedge clk);
		check_bits("priority step 5", pulse_vec(), 6'b000_001);
		ref_lines[ref_index(addr_a)] = new_a;
		read_check(PORT_DATA, addr_a);
	endtask

	task automatic test_random_alias();
		cpu_addr_t written[$];
		cpu_addr_t addr;
		line_data_t data;
		logic [31:0] r;
		int pick;
		write_line(32'h0000_0208, 64'h0a0a_0b0b_0c0c_0d0d);
		read_check(PORT_DATA, 32'hffff_fa08);
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			r = $random(seed);
			if (written.size() == 0 || r[0])
			begin
				addr = $random(seed);
				data = {$random(seed), $random(seed)};
				write_line(addr, data);
				written.push_back(addr);
			end
			else
			begin
				pick = int'(r[15:8]) % written.size();
				addr = written[pick] ^ ($random(seed) & ALIAS_MASK);
				read_check(r[1] ? PORT_INSTR : PORT_DATA, addr);
			end
		end
	endtask

	// staggered reqs accepted on three consecutive edges
	task automatic test_pipeline();
		cpu_addr_t addr_c;
		cpu_addr_t addr_d;
		line_data_t new_c;
		addr_c = 32'h0000_03f8;
		addr_d = 32'h0000_0400;
		new_c = 64'h0f0f_1e1e_2d2d_3c3c;
		write_line(addr_d, 64'h7e7e_6d6d_5c5c_4b4b);
		@(negedge clk);
		drive_read(PORT_DATA, 1'b1, addr_d);
		@(negedge clk);
		check_bits("pipeline step 1", pulse_vec(), 6'b010_000);
		drive_read(PORT_DATA, 1'b0, addr_d);
		drive_write(1'b1, addr_c, new_c);
		@(negedge clk);
		check_bits("pipeline step 2", pulse_vec(), 6'b001_000);
		drive_write(1'b0, addr_c, new_c);
		drive_read(PORT_INSTR, 1'b1, addr_c);
		@(negedge clk);
		check_bits("pipeline step 3", pulse_vec(), 6'b100_010);
		check_line("pipeline data read", rsp_read_data.data, ref_lines[ref_index(addr_d)]);
		drive_read(PORT_INSTR, 1'b0, addr_c);
		@(negedge clk);
		check_bits("pipeline step 4", pulse_vec(), 6'b000_001);
		ref_lines[ref_index(addr_c)] = new_c;
		@(negedge clk);
		check_bits("pipeline step 5", pulse_vec(), 6'b000_100);
		check_line("pipeline instr read", rsp_read_instr.data, new_c);
	endtask

	initial
	begin
		seed = 72;
		checks = 0;
		errors = 0;
		rst = 1'b1;
		req_read_instr = '0;
		req_read_data = '0;
		req_write_data = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_write_then_read();
		test_instr_read();
		test_priority();
		test_random_alias();
		test_pipeline();
		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== mem_bus_guard_asserts.sv ====
`timescale 1ns/1ps

module mem_bus_guard_asserts
(
	input logic clk,
	input logic rst,
	input logic acc_read_instr,
	input logic acc_read_data,
	input logic acc_write_data,
	input logic vld_read_instr,
	input logic vld_read_data,
	input logic vld_write_data,
	input logic mem_req
);

	// instruction read in the top bit
	logic [2:0] acc;
	logic [2:0] vld;

	assign acc = {acc_read_instr, acc_read_data, acc_write_data};
	assign vld = {vld_read_instr, vld_read_data, vld_write_data};

	single_accept: assert property (@(posedge clk) disable iff (rst) $onehot0(acc))
		else $error("more than one cmd_accepted high in the same cycle");

	// a port sits out the cycle its cmd_accepted is high
	no_repeat_accept: assert property (@(posedge clk) disable iff (rst)
		(acc & $past(acc)) == 3'b000)
		else $error("cmd_accepted high two cycles in a row on one port");

	valid_follows_accept: assert property (@(posedge clk) disable iff (rst)
		(vld & $past(acc, 2)) == $past(acc, 2))
		else $error("cmd_accepted not followed by valid two cycles later");

	mem_req_matches_accept: assert property (@(posedge clk) disable iff (rst)
		mem_req == (acc != 3'b000))
		else $error("mem req does not match cmd_accepted");

endmodule

bind mem_bus_guard mem_bus_guard_asserts asserts_i
(
	.clk            (clk),
	.rst            (rst),
	.acc_read_instr (acc_read_instr),
	.acc_read_data  (acc_read_data),
	.acc_write_data (acc_write_data),
	.vld_read_instr (vld_read_instr),
	.vld_read_data  (vld_read_data),
	.vld_write_data (vld_write_data),
	.mem_req        (mem_access.req)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk
);

	// 100 ns period, first rising edge at 50 ns
	initial
	begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

endmodule

// ==== mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top
(
	input  logic                    clk,
	input  logic                    rst,
	input  mem_bus_pkg::read_req_t  req_read_instr,
	input  mem_bus_pkg::read_req_t  req_read_data,
	input  mem_bus_pkg::write_req_t req_write_data,
	output mem_bus_pkg::read_rsp_t  rsp_read_instr,
	output mem_bus_pkg::read_rsp_t  rsp_read_data,
	output mem_bus_pkg::write_rsp_t rsp_write_data
);

	import cpu_pkg::*;
	import mem_bus_pkg::*;

	// guard to RAM access
	mem_access_t mem_access;

	// RAM line back to the guard
	line_data_t mem_rdata;

	mem_bus_guard guard_i
	(
		.clk            (clk),
		.rst            (rst),
		.req_read_instr (req_read_instr),
		.req_read_data  (req_read_data),
		.req_write_data (req_write_data),
		.mem_rdata      (mem_rdata),
		.rsp_read_instr (rsp_read_instr),
		.rsp_read_data  (rsp_read_data),
		.rsp_write_data (rsp_write_data),
		.mem_access     (mem_access)
	);

	line_ram ram_i
	(
		.clk        (clk),
		.mem_access (mem_access),
		.rdata      (mem_rdata)
	);

endmodule

// ==== mem_bus_guard.sv ====
`timescale 1ns/1ps

module mem_bus_guard
(
	input  logic                    clk,
	input  logic                    rst,
	input  mem_bus_pkg::read_req_t  req_read_instr,
	input  mem_bus_pkg::read_req_t  req_read_data,
	input  mem_bus_pkg::write_req_t req_write_data,
	input  cpu_pkg::line_data_t     mem_rdata,
	output mem_bus_pkg::read_rsp_t  rsp_read_instr,
	output mem_bus_pkg::read_rsp_t  rsp_read_data,
	output mem_bus_pkg::write_rsp_t rsp_write_data,
	output mem_bus_pkg::mem_access_t mem_access
);

	import cpu_pkg::*;
	import mem_bus_pkg::*;

	// request kind travelling down the pipeline
	req_type_t grant_type;
	req_type_t stage_0_to_1_type;
	req_type_t stage_1_to_2_type;

	// per-port eligibility for stage 0
	logic elig_read_instr;
	logic elig_read_data;
	logic elig_write_data;

	// cmd_accepted pulses, set by stage 0
	logic acc_read_instr;
	logic acc_read_data;
	logic acc_write_data;

	// valid pulses and returned lines, set by stage 2
	logic vld_read_instr;
	logic vld_read_data;
	logic vld_write_data;
	line_data_t data_read_instr;
	line_data_t data_read_data;

	// a port whose cmd_accepted is high this cycle sits out, so it can drop req
	assign elig_read_instr = req_read_instr.req && !acc_read_instr;
	assign elig_read_data  = req_read_data.req && !acc_read_data;
	assign elig_write_data = req_write_data.req && !acc_write_data;

	// fixed priority: instruction read, data read, data write
	always_comb
	begin
		if (elig_read_instr)
		begin
			grant_type = REQ_READ_INSTR;
		end
		else if (elig_read_data)
		begin
			grant_type = REQ_READ_DATA;
		end
		else if (elig_write_data)
		begin
			grant_type = REQ_WRITE_DATA;
		end
		else
		begin
			grant_type = REQ_NONE;
		end
	end

	// stage 0
	// accept the winner and drive the memory bus in the following cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_read_instr <= 1'b0;
			acc_read_data <= 1'b0;
			acc_write_data <= 1'b0;
			mem_access.req <= 1'b0;
			stage_0_to_1_type <= REQ_NONE;
		end
		else
		begin
			acc_read_instr <= (grant_type == REQ_READ_INSTR);
			acc_read_data <= (grant_type == REQ_READ_DATA);
			acc_write_data <= (grant_type == REQ_WRITE_DATA);
			mem_access.req <= (grant_type != REQ_NONE);
			stage_0_to_1_type <= grant_type;
		end

		// bus payload follows the winning port
		case (grant_type)
			REQ_READ_DATA:
			begin
				mem_access.addr <= req_read_data.addr;
				mem_access.acc_type <= MEM_ACC_READ;
			end
			REQ_WRITE_DATA:
			begin
				mem_access.addr <= req_write_data.addr;
				mem_access.data <= req_write_data.data;
				mem_access.acc_type <= MEM_ACC_WRITE;
			end
			default:
			begin
				mem_access.addr <= req_read_instr.addr;
				mem_access.acc_type <= MEM_ACC_READ;
			end
		endcase
	end

	// stage 1
	// nothing to do while the RAM samples the access and registers its line
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stage_1_to_2_type <= REQ_NONE;
		end
		else
		begin
			stage_1_to_2_type <= stage_0_to_1_type;
		end
	end

	// stage 2
	// tell the requester its access is done, and hand back the line on reads
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vld_read_instr <= 1'b0;
			vld_read_data <= 1'b0;
			vld_write_data <= 1'b0;
			data_read_instr <= '0;
			data_read_data <= '0;
		end
		else
		begin
			vld_read_instr <= (stage_1_to_2_type == REQ_READ_INSTR);
			vld_read_data <= (stage_1_to_2_type == REQ_READ_DATA);
			vld_write_data <= (stage_1_to_2_type == REQ_WRITE_DATA);

			if (stage_1_to_2_type == REQ_READ_INSTR)
			begin
				data_read_instr <= mem_rdata;
			end

			if (stage_1_to_2_type == REQ_READ_DATA)
			begin
				data_read_data <= mem_rdata;
			end
		end
	end

	assign rsp_read_instr.valid = vld_read_instr;
	assign rsp_read_instr.cmd_accepted = acc_read_instr;
	assign rsp_read_instr.data = data_read_instr;

	assign rsp_read_data.valid = vld_read_data;
	assign rsp_read_data.cmd_accepted = acc_read_data;
	assign rsp_read_data.data = data_read_data;

	assign rsp_write_data.valid = vld_write_data;
	assign rsp_write_data.cmd_accepted = acc_write_data;

endmodule

// ==== line_ram.sv ====
`timescale 1ns/1ps

module line_ram
(
	input  logic                     clk,
	input  mem_bus_pkg::mem_access_t mem_access,
	output cpu_pkg::line_data_t      rdata
);

	import cpu_pkg::*;
	import mem_bus_pkg::*;

	// line storage, contents come up undefined
	line_data_t lines [RAM_DEPTH];

	// line picked by the current access
	line_index_t index;

	// decoded access kind for this cycle
	logic do_write;
	logic do_read;

	assign index = line_index(mem_access.addr);

	assign do_write = mem_access.req && (mem_access.acc_type == MEM_ACC_WRITE);
	assign do_read  = mem_access.req && (mem_access.acc_type == MEM_ACC_READ);

	// write lands at the sampling edge
	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			lines[index] <= mem_access.data;
		end
	end

	// read line is registered at the sampling edge
	// and held until the next read
	always_ff @(posedge clk)
	begin
		if (do_read)
		begin
			rdata <= lines[index];
		end
	end

endmodule

// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

	// what a guard pipeline stage is carrying
	typedef enum logic [1:0]
	{
		REQ_NONE       = 2'd0,
		REQ_READ_INSTR = 2'd1,
		REQ_READ_DATA  = 2'd2,
		REQ_WRITE_DATA = 2'd3
	} req_type_t;

	// kind of access driven onto the memory bus
	typedef enum logic
	{
		MEM_ACC_READ  = 1'b0,
		MEM_ACC_WRITE = 1'b1
	} mem_acc_type_t;

	// read requester side, held until cmd_accepted pulses
	typedef struct packed
	{
		logic req;
		cpu_pkg::cpu_addr_t addr;
	} read_req_t;

	// write requester side, addr and data stay stable with req
	typedef struct packed
	{
		logic req;
		cpu_pkg::cpu_addr_t addr;
		cpu_pkg::line_data_t data;
	} write_req_t;

	// returned to a read requester
	// cmd_accepted and valid are one-cycle pulses
	typedef struct packed
	{
		logic valid;
		logic cmd_accepted;
		cpu_pkg::line_data_t data;
	} read_rsp_t;

	// returned to the write requester
	typedef struct packed
	{
		logic valid;
		logic cmd_accepted;
	} write_rsp_t;

	// guard to RAM, one access per cycle at most
	typedef struct packed
	{
		logic req;
		cpu_pkg::cpu_addr_t addr;
		cpu_pkg::line_data_t data;
		mem_acc_type_t acc_type;
	} mem_access_t;

endpackage

// ==== cpu_pkg.sv ====
package cpu_pkg;

	// byte address and memory line sizes
	localparam int ADDR_WIDTH = 32;
	localparam int LINE_WIDTH = 64;

	// number of lines held by the block RAM
	localparam int RAM_DEPTH = 256;

	// a line is 8 bytes, so the lowest 3 address bits pick a byte in the line
	localparam int LINE_OFFSET_WIDTH = 3;
	localparam int LINE_INDEX_WIDTH = $clog2(RAM_DEPTH);

	typedef logic [ADDR_WIDTH-1:0] cpu_addr_t;
	typedef logic [LINE_WIDTH-1:0] line_data_t;
	typedef logic [LINE_INDEX_WIDTH-1:0] line_index_t;

	// line index is the address bits just above the byte offset
	// higher address bits alias onto the same line
	function automatic line_index_t line_index(input cpu_addr_t addr);
		return addr[LINE_OFFSET_WIDTH +: LINE_INDEX_WIDTH];
	endfunction

endpackage
